//--- Bender.yml
package:
  name: cdr_ctrl

sources:
  - source/cdr_pkg.sv
  - source/cdr_reg_if.sv
  - source/phase_window_counter.sv
  - source/picode_history.sv
  - source/picode_tracker.sv
  - source/cdr_top.sv
  - target: test
    files:
      - testbench/cdr_tb.sv

//--- source/cdr_pkg.sv
/*
 * Shared constants and enums for the CDR control block
 * Code widths, lock rule values, tracker states, window and register selects
 */
package cdr_pkg;

	// Interpolator code and history sizes
	parameter int PICODE_W = 7;
	parameter int HIST_DEPTH = 32;

	// Lock rule
	parameter int LOCK_WINDOWS = 17;	// Consecutive close windows
	parameter int LOCK_TOL = 2;	// Max code to average distance

	// Tracker FSM states
	typedef enum logic {
		CDR_START,
		CDR_RUN
	} cdr_state_t;

	// Window length select, N = 8 << win_sel
	typedef enum logic [1:0] {
		WIN_8 = 2'd0,
		WIN_16 = 2'd1,
		WIN_32 = 2'd2,
		WIN_64 = 2'd3
	} win_sel_t;

	// Wishbone word addresses
	typedef enum logic [1:0] {
		REG_CTRL = 2'd0,
		REG_OVRD = 2'd1,
		REG_STATUS = 2'd2
	} reg_addr_t;

endpackage

//--- source/cdr_reg_if.sv
/*
 * Wishbone classic slave for the CDR block
 * Control and override registers, live status readback, single-cycle ack
 */
`timescale 1ns/1ps

module cdr_reg_if (
	input logic sys_clk,
	input logic sync_rst_n,

	// Wishbone classic slave
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [1:0] wb_adr,
	input logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack,

	// Live status from the tracker
	input logic cdr_lock,
	input logic [cdr_pkg::PICODE_W-1:0] picode_even,
	input logic [cdr_pkg::PICODE_W-1:0] picode_odd,

	// Control fields
	output logic rx_en,
	output cdr_pkg::win_sel_t win_sel,
	output logic ovrd_sel,
	output logic lock_ovrd,
	output logic update_ovrd,
	output logic [cdr_pkg::PICODE_W-1:0] ovrd_even,
	output logic [cdr_pkg::PICODE_W-1:0] ovrd_odd
);
	import cdr_pkg::*;

	reg_addr_t addr;
	logic wb_req;	// First cycle of a new access
	logic [31:0] ctrl_word;
	logic [31:0] ovrd_word;
	logic [31:0] status_word;

	assign addr = reg_addr_t'(wb_adr);
	assign wb_req = wb_cyc && wb_stb && !wb_ack;

	// Ack for one cycle, then low again while the master drops stb
	always_ff @(posedge sys_clk or negedge sync_rst_n)
	begin
		if (!sync_rst_n)
			wb_ack <= 1'b0;
		else
			wb_ack <= wb_req;
	end

	// Writes land on the same edge that raises ack
	always_ff @(posedge sys_clk or negedge sync_rst_n)
	begin
		if (!sync_rst_n)
		begin
			rx_en <= 1'b0;
			ovrd_sel <= 1'b0;
			lock_ovrd <= 1'b0;
			update_ovrd <= 1'b0;
			win_sel <= WIN_8;
			ovrd_even <= '0;
			ovrd_odd <= '0;
		end
		else if (wb_req && wb_we)
		begin
			case (addr)
				REG_CTRL:
				begin
					rx_en <= wb_dat_w[0];
					ovrd_sel <= wb_dat_w[1];
					lock_ovrd <= wb_dat_w[2];
					update_ovrd <= wb_dat_w[3];
					win_sel <= win_sel_t'(wb_dat_w[5:4]);
				end
				REG_OVRD:
				begin
					ovrd_even <= wb_dat_w[PICODE_W-1:0];
					ovrd_odd <= wb_dat_w[8 +: PICODE_W];
				end
				default: ;	// Status is read-only
			endcase
		end
	end

	// Readback words, unused bits zero
	always_comb
	begin
		ctrl_word = '0;
		ctrl_word[0] = rx_en;
		ctrl_word[1] = ovrd_sel;
		ctrl_word[2] = lock_ovrd;
		ctrl_word[3] = update_ovrd;
		ctrl_word[5:4] = win_sel;

		ovrd_word = '0;
		ovrd_word[PICODE_W-1:0] = ovrd_even;
		ovrd_word[8 +: PICODE_W] = ovrd_odd;

		status_word = '0;
		status_word[0] = cdr_lock;
		status_word[8 +: PICODE_W] = picode_even;
		status_word[16 +: PICODE_W] = picode_odd;
	end

	// Master holds the address through the ack cycle
	always_comb
	begin
		case (addr)
			REG_CTRL: wb_dat_r = ctrl_word;
			REG_OVRD: wb_dat_r = ovrd_word;
			REG_STATUS: wb_dat_r = status_word;
			default: wb_dat_r = '0;
		endcase
	end

endmodule

//--- source/cdr_top.sv
/*
 * CDR control top level
 * Register slave, vote counter, code history and code tracker
 */
`timescale 1ns/1ps

module cdr_top #(
	parameter int PICODE_W = cdr_pkg::PICODE_W,
	parameter int HIST_DEPTH = cdr_pkg::HIST_DEPTH
) (
	input logic sys_clk,
	input logic sync_rst_n,
	input logic phase_detect,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [1:0] wb_adr,
	input logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack,
	output logic [PICODE_W-1:0] picode_even,
	output logic [PICODE_W-1:0] picode_odd,
	output logic picode_update,
	output logic cdr_lock
);
	import cdr_pkg::*;

	win_sel_t win_sel;
	logic rx_en;
	logic ovrd_sel;
	logic lock_ovrd;
	logic update_ovrd;
	logic [PICODE_W-1:0] ovrd_even;
	logic [PICODE_W-1:0] ovrd_odd;
	logic win_done;
	logic step_up;
	logic step_down;
	logic hist_push;
	logic hist_clear;
	logic [PICODE_W-1:0] hist_code;
	logic [PICODE_W-1:0] hist_avg;

	cdr_reg_if u_reg_if (
		.sys_clk, .sync_rst_n,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
		.cdr_lock, .picode_even, .picode_odd,	// Status readback
		.rx_en, .win_sel, .ovrd_sel, .lock_ovrd, .update_ovrd, .ovrd_even, .ovrd_odd
	);

	phase_window_counter #(.PICODE_W(PICODE_W)) u_window (
		.sys_clk, .sync_rst_n,
		.phase_detect, .rx_en, .win_sel,
		.win_done, .step_up, .step_down
	);

	picode_history #(.PICODE_W(PICODE_W), .HIST_DEPTH(HIST_DEPTH)) u_history (
		.sys_clk, .sync_rst_n,
		.hist_push, .hist_clear, .hist_code, .hist_avg
	);

	picode_tracker #(.PICODE_W(PICODE_W)) u_tracker (
		.sys_clk, .sync_rst_n, .rx_en,
		.win_done, .step_up, .step_down,
		.hist_avg, .hist_push, .hist_clear, .hist_code,
		.ovrd_sel, .lock_ovrd, .update_ovrd, .ovrd_even, .ovrd_odd,
		.picode_even, .picode_odd, .picode_update, .cdr_lock
	);

endmodule

//--- source/phase_window_counter.sv
/*
 * Phase detector vote counter
 * Two-flop synchronizer, windowed late-vote count and step decision
 */
`timescale 1ns/1ps

module phase_window_counter #(
	parameter int PICODE_W = cdr_pkg::PICODE_W
) (
	input logic sys_clk,
	input logic sync_rst_n,
	input logic phase_detect,	// From the receive DLL, async
	input logic rx_en,
	input cdr_pkg::win_sel_t win_sel,
	output logic win_done,
	output logic step_up,
	output logic step_down
);
	import cdr_pkg::*;

	// Counters share the code width, the 64-cycle window still fits
	logic ph_meta;
	logic ph_sync;
	logic [PICODE_W-1:0] cycle_cnt;
	logic [PICODE_W-1:0] late_cnt;
	logic [PICODE_W-1:0] late_next;
	logic [PICODE_W-1:0] win_len;
	logic [PICODE_W-1:0] thr_lo;
	logic [PICODE_W-1:0] thr_hi;
	logic win_end;

	always_comb
	begin
		case (win_sel)
			WIN_8: win_len = PICODE_W'(8);
			WIN_16: win_len = PICODE_W'(16);
			WIN_32: win_len = PICODE_W'(32);
			default: win_len = PICODE_W'(64);
		endcase
	end

	assign thr_lo = win_len >> 2;	// N/4
	assign thr_hi = thr_lo + (thr_lo << 1);	// 3N/4

	// Greater-or-equal also closes a window shortened mid-count
	assign win_end = rx_en && (cycle_cnt >= win_len - 1'b1);
	assign late_next = late_cnt + {{(PICODE_W-1){1'b0}}, ph_sync};

	always_ff @(posedge sys_clk or negedge sync_rst_n)
	begin
		if (!sync_rst_n)
		begin
			ph_meta <= 1'b0;
			ph_sync <= 1'b0;
			cycle_cnt <= '0;
			late_cnt <= '0;
			win_done <= 1'b0;
			step_up <= 1'b0;
			step_down <= 1'b0;
		end
		else
		begin
			ph_meta <= phase_detect;
			ph_sync <= ph_meta;
			win_done <= win_end;
			step_up <= win_end && (late_next > thr_hi);
			step_down <= win_end && (late_next < thr_lo);
			if (win_end)
			begin
				cycle_cnt <= '0;	// Restart for the next window
				late_cnt <= '0;
			end
			else if (rx_en)
			begin
				cycle_cnt <= cycle_cnt + 1'b1;
				late_cnt <= late_next;
			end
		end
	end

endmodule

//--- source/picode_history.sv
/*
 * Ring of past interpolator codes
 * Write index, running sum and average over the full ring
 */
`timescale 1ns/1ps

module picode_history #(
	parameter int PICODE_W = cdr_pkg::PICODE_W,
	parameter int HIST_DEPTH = cdr_pkg::HIST_DEPTH
) (
	input logic sys_clk,
	input logic sync_rst_n,
	input logic hist_push,
	input logic hist_clear,
	input logic [PICODE_W-1:0] hist_code,
	output logic [PICODE_W-1:0] hist_avg
);

	localparam int IDX_W = $clog2(HIST_DEPTH);
	localparam int SUM_W = PICODE_W + IDX_W;	// Holds HIST_DEPTH full-scale codes

	logic [PICODE_W-1:0] ring [HIST_DEPTH];
	logic [IDX_W-1:0] wr_idx;
	logic [SUM_W-1:0] code_sum;

	// Entries are zeroed by hist_clear, which the tracker holds after reset
	always_ff @(posedge sys_clk)
	begin
		if (hist_clear)
		begin
			for (int i = 0; i < HIST_DEPTH; i++)
				ring[i] <= '0;
		end
		else if (hist_push)
			ring[wr_idx] <= hist_code;
	end

	always_ff @(posedge sys_clk or negedge sync_rst_n)
	begin
		if (!sync_rst_n)
		begin
			wr_idx <= '0;
			code_sum <= '0;
		end
		else if (hist_clear)
		begin
			wr_idx <= '0;
			code_sum <= '0;
		end
		else if (hist_push)
		begin
			// Drop the oldest entry, add the new one
			code_sum <= code_sum - SUM_W'(ring[wr_idx]) + SUM_W'(hist_code);
			if (wr_idx == IDX_W'(HIST_DEPTH - 1))
				wr_idx <= '0;
			else
				wr_idx <= wr_idx + 1'b1;
		end
	end

	assign hist_avg = code_sum[SUM_W-1 -: PICODE_W];	// Sum / HIST_DEPTH

endmodule

//--- source/picode_tracker.sv
/*
 * Interpolator code tracker
 * Start/run FSM, code stepping, history push, lock detect and override mux
 */
`timescale 1ns/1ps

module picode_tracker #(
	parameter int PICODE_W = cdr_pkg::PICODE_W
) (
	input logic sys_clk,
	input logic sync_rst_n,
	input logic rx_en,

	// Window decisions
	input logic win_done,
	input logic step_up,
	input logic step_down,

	// History ring
	input logic [PICODE_W-1:0] hist_avg,
	output logic hist_push,
	output logic hist_clear,
	output logic [PICODE_W-1:0] hist_code,

	// Register overrides
	input logic ovrd_sel,
	input logic lock_ovrd,
	input logic update_ovrd,
	input logic [PICODE_W-1:0] ovrd_even,
	input logic [PICODE_W-1:0] ovrd_odd,

	// To the interpolators
	output logic [PICODE_W-1:0] picode_even,
	output logic [PICODE_W-1:0] picode_odd,
	output logic picode_update,
	output logic cdr_lock
);
	import cdr_pkg::*;

	localparam int LOCK_CNT_W = $clog2(LOCK_WINDOWS + 1);
	localparam logic [LOCK_CNT_W-1:0] LOCK_MAX = LOCK_CNT_W'(LOCK_WINDOWS);
	localparam logic [PICODE_W-1:0] TOL = PICODE_W'(LOCK_TOL);
	localparam logic [PICODE_W-1:0] HALF_TURN = {1'b1, {(PICODE_W-1){1'b0}}};	// 180 degrees

	cdr_state_t state_q;
	cdr_state_t state_d;
	logic [PICODE_W-1:0] even_q;
	logic [PICODE_W-1:0] odd_int;
	logic [PICODE_W-1:0] dist_pos;
	logic [PICODE_W-1:0] dist_neg;
	logic [LOCK_CNT_W-1:0] lock_cnt;
	logic update_q;
	logic lock_q;
	logic code_close;

	always_comb
	begin
		case (state_q)
			CDR_START: state_d = rx_en ? CDR_RUN : CDR_START;
			CDR_RUN: state_d = rx_en ? CDR_RUN : CDR_START;
			default: state_d = CDR_START;
		endcase
	end

	// Wrapped distance in both directions, code taken before the step
	assign dist_pos = even_q - hist_avg;
	assign dist_neg = hist_avg - even_q;
	assign code_close = (dist_pos <= TOL) || (dist_neg <= TOL);

	always_ff @(posedge sys_clk or negedge sync_rst_n)
	begin
		if (!sync_rst_n)
		begin
			state_q <= CDR_START;
			even_q <= '0;
			update_q <= 1'b0;
			lock_cnt <= '0;
			lock_q <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			update_q <= 1'b0;
			if (state_q == CDR_START)
				lock_cnt <= '0;	// Code and lock survive a restart
			else if (win_done)
			begin
				if (step_up)
				begin
					even_q <= even_q + 1'b1;
					update_q <= 1'b1;
				end
				else if (step_down)
				begin
					even_q <= even_q - 1'b1;
					update_q <= 1'b1;
				end

				if (!code_close)
					lock_cnt <= '0;
				else if (lock_cnt < LOCK_MAX)
					lock_cnt <= lock_cnt + 1'b1;

				if (code_close && (lock_cnt >= LOCK_MAX - 1'b1))
					lock_q <= 1'b1;	// Sticky until reset
			end
		end
	end

	assign odd_int = even_q + HALF_TURN;

	// History sees the pre-step code once per window
	assign hist_push = (state_q == CDR_RUN) && win_done;
	assign hist_clear = (state_q == CDR_START);
	assign hist_code = even_q;

	// Override mux
	assign picode_even = ovrd_sel ? ovrd_even : even_q;
	assign picode_odd = ovrd_sel ? ovrd_odd : odd_int;
	assign picode_update = ovrd_sel ? update_ovrd : update_q;
	assign cdr_lock = ovrd_sel ? lock_ovrd : lock_q;

endmodule

//--- testbench/cdr_cases.txt
# All fields hex. W addr data | R addr expected | P mode (0 low, 1 high, 2 half)
# U updates | Q cycles without update | L wait lock | E even odd lock update
R 2 00400000
E 00 40 0 0
W 0 0000003C
W 1 FFFF5A35
W 2 FFFFFFFF
R 0 0000003C
R 1 00005A35
R 2 00400000
# Track up with 8-cycle windows, then wrap past 127
P 1
W 0 00000001
U 3
E 03 43 0 0
U 7C
E 7F 3F 0 0
U 1
E 00 40 0 0
# Track down through every window length
P 0
W 0 00000011
U 2
E 7E 3E 0 0
W 0 00000021
U 2
E 7C 3C 0 0
W 0 00000031
U 2
E 7A 3A 0 0
W 0 00000001
U 2
E 78 38 0 0
# Back to zero, clear history, hold until lock
P 1
W 0 00000031
U 8
E 00 40 0 0
P 2
W 0 00000030
W 0 00000031
Q 100
E 00 40 0 0
L
E 00 40 1 0
R 2 00400001
# Override then release
W 0 0000003B
E 35 5A 0 1
R 2 005A3500
W 0 00000031
E 00 40 1 0
R 0 00000031
R 1 00005A35

//--- testbench/cdr_tb.sv
/*
 * Testbench for the CDR control block
 * Replays the cases file over Wishbone and phase_detect, checks ports and registers
 */
`timescale 1ns/1ps

module cdr_tb;
	import cdr_pkg::*;

	localparam int ACK_LIMIT = 20;
	localparam int UPDATE_LIMIT = 300;	// Two 64-cycle windows plus slack
	localparam int LOCK_LIMIT = 3000;

	logic sys_clk;
	logic sync_rst_n;
	logic phase_detect;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [1:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic wb_ack;
	logic [PICODE_W-1:0] picode_even;
	logic [PICODE_W-1:0] picode_odd;
	logic picode_update;
	logic cdr_lock;

	logic [1:0] phase_mode;	// 0 low, 1 high, 2 half
	logic [7:0] half_pat;
	logic [2:0] half_idx;
	logic [PICODE_W-1:0] model_even;	// Expected even code, stepped per update
	int err_cnt;
	int op_cnt;
	int fd;
	string line;
	logic [7:0] op;
	logic [31:0] f0;
	logic [31:0] f1;
	logic [31:0] f2;
	logic [31:0] f3;
	logic [31:0] rdata;
	reg_addr_t adr;

	cdr_top #(.PICODE_W(PICODE_W), .HIST_DEPTH(HIST_DEPTH)) dut0 (
		.sys_clk, .sync_rst_n, .phase_detect,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
		.picode_even, .picode_odd, .picode_update, .cdr_lock
	);

	always #2 sys_clk = ~sys_clk;

	// Phase detector model, the half pattern repeats every 8 cycles
	always @(posedge sys_clk)
	begin
		case (phase_mode)
			2'd0: phase_detect <= 1'b0;
			2'd1: phase_detect <= 1'b1;
			default: phase_detect <= half_pat[half_idx];
		endcase
		half_idx <= half_idx + 1'b1;
	end

	task automatic abort_run(input string why);
		err_cnt++;
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
		abort_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// One classic cycle, master holds cyc and stb until ack
	task automatic wb_access(input logic we, input reg_addr_t a, input logic [31:0] wdat,
			output logic [31:0] rdat);
		int wait_cnt;
		wait_cnt = 0;
		@(posedge sys_clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= a;
		wb_dat_w <= wdat;
		do
		begin
			@(negedge sys_clk);
			wait_cnt++;
		end
		while (!wb_ack && wait_cnt < ACK_LIMIT);
		assert (wb_ack) else abort_run("Wishbone ack did not arrive");
		rdat = wb_dat_r;
		@(posedge sys_clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
		@(negedge sys_clk);
		assert (!wb_ack) else value_error("wb_ack", wb_ack, 0);	// Ack lasts one cycle
	endtask

	// Four late votes in eight, order from the seeded generator
	task automatic shuffle_half;
		logic [7:0] pat;
		int j;
		logic tmp;
		pat = 8'h0f;
		for (int i = 7; i > 0; i--)
		begin
			j = $urandom % (i + 1);
			tmp = pat[i];
			pat[i] = pat[j];
			pat[j] = tmp;
		end
		half_pat = pat;
	endtask

	// Each update moves the even code one step toward the votes
	task automatic wait_updates(input int count);
		int seen;
		int idle;
		logic [PICODE_W-1:0] exp_odd;
		seen = 0;
		while (seen < count)
		begin
			idle = 0;
			do
			begin
				@(negedge sys_clk);
				idle++;
			end
			while (!picode_update && idle < UPDATE_LIMIT);
			assert (picode_update)
			else abort_run($sformatf("No code update after %0d of %0d updates", seen, count));
			if (phase_mode == 2'd1)
				model_even = model_even + 1'b1;
			else
				model_even = model_even - 1'b1;
			exp_odd = model_even + PICODE_W'(64);	// Odd clock half a turn away
			assert (picode_even == model_even)
			else value_error("picode_even", picode_even, model_even);
			assert (picode_odd == exp_odd) else value_error("picode_odd", picode_odd, exp_odd);
			seen++;
		end
	endtask

	task automatic wait_lock;
		int cyc;
		cyc = 0;
		do
		begin
			@(negedge sys_clk);
			cyc++;
		end
		while (!cdr_lock && cyc < LOCK_LIMIT);
		assert (cdr_lock) else abort_run("cdr_lock did not rise within the lock timeout");
	endtask

	task automatic quiet_check(input int cycles);
		repeat (cycles)
		begin
			@(negedge sys_clk);
			assert (!picode_update) else value_error("picode_update", picode_update, 0);
		end
	endtask

	task automatic check_ports(input logic [31:0] even, input logic [31:0] odd,
			input logic [31:0] lock, input logic [31:0] upd);
		@(negedge sys_clk);
		assert (picode_even == even) else value_error("picode_even", picode_even, even);
		assert (picode_odd == odd) else value_error("picode_odd", picode_odd, odd);
		assert (cdr_lock == lock[0]) else value_error("cdr_lock", cdr_lock, lock);
		assert (picode_update == upd[0]) else value_error("picode_update", picode_update, upd);
	endtask

	initial
	begin
		sys_clk = 1'b0;
		sync_rst_n = 1'b0;
		phase_detect = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 2'd0;
		wb_dat_w = 32'd0;
		phase_mode = 2'd0;
		half_pat = 8'h0f;
		half_idx = 3'd0;
		model_even = '0;
		err_cnt = 0;
		op_cnt = 0;
		void'($urandom(32'h4784bb59));
		repeat (5) @(posedge sys_clk);
		sync_rst_n <= 1'b1;

		fd = $fopen("testbench/cdr_cases.txt", "r");
		assert (fd != 0) else abort_run("Cannot open testbench/cdr_cases.txt");
		while ($fgets(line, fd) != 0)
		begin
			if (line.len() < 1 || line[0] == "#" || line[0] == "\n")
				continue;	// Comment or blank line
			void'($sscanf(line, "%c %h %h %h %h", op, f0, f1, f2, f3));
			adr = reg_addr_t'(f0[1:0]);
			op_cnt++;
			case (op)
				"W": wb_access(1'b1, adr, f1, rdata);
				"R":
				begin
					wb_access(1'b0, adr, 32'd0, rdata);
					assert (rdata == f1)
					else value_error($sformatf("wb_dat_r at %s", adr.name()), rdata, f1);
				end
				"P":
				begin
					@(negedge sys_clk);
					if (f0 == 32'd2)
						shuffle_half();
					phase_mode = f0[1:0];
				end
				"U": wait_updates(f0);
				"Q": quiet_check(f0);
				"L": wait_lock();
				"E": check_ports(f0, f1, f2, f3);
				default: abort_run($sformatf("Unknown operation in cases file: %s", line));
			endcase
		end
		$fclose(fd);
		assert (op_cnt > 0) else abort_run("Cases file holds no operations");

		if (err_cnt == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- verilog.f
source/cdr_pkg.sv
source/cdr_reg_if.sv
source/phase_window_counter.sv
source/picode_history.sv
source/picode_tracker.sv
source/cdr_top.sv
testbench/cdr_tb.sv
